// ==== Makefile ====
TOP := tb_csr_unit
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== build.f ====
verilog/csr_arch_pkg.sv
verilog/csr_pipe_pkg.sv
verilog/csr_timer.sv
verilog/csr_decode.sv
verilog/csr_regfile.sv
verilog/csr_unit.sv
testbench/csr_unit_props.sv
testbench/tb_csr_unit.sv

// ==== testbench/csr_unit_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_unit_props (
    input logic                    clk,
    input logic                    rstn,
    input logic                    stall,
    input csr_pipe_pkg::csr_resp_t resp
);

    flush_has_valid: assert property (@(posedge clk) disable iff (!rstn)
        resp.flush |-> resp.valid)
        else $error("resp.flush high without resp.valid");

    int_has_flush: assert property (@(posedge clk) disable iff (!rstn)
        resp.int_taken |-> resp.flush)
        else $error("resp.int_taken high without resp.flush");

    // sync reset, so the clear shows one edge later
    reset_clears_valid: assert property (@(posedge clk)
        !rstn |=> !resp.valid)
        else $error("resp.valid high while in reset");

    stall_holds_valid: assert property (@(posedge clk) disable iff (!rstn)
        stall |=> $stable(resp.valid))
        else $error("resp.valid changed during stall");

endmodule

bind csr_unit csr_unit_props u_csr_unit_props (
    .clk   (clk),
    .rstn  (rstn),
    .stall (stall),
    .resp  (resp)
);

`default_nettype wire

// ==== testbench/tb_csr_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_csr_unit;
    import csr_arch_pkg::*;
    import csr_pipe_pkg::*;

    localparam int N_ITER      = 40;
    localparam int CYCLE_LIMIT = (N_ITER * 15 + 400) * 20;   // ~20 cycles per request

    logic       clk;
    logic       rstn;
    csr_req_t   req;
    logic       stall;
    logic       flush;
    logic [7:0] hw_int;
    csr_resp_t  resp;

    integer seed;
    int     err_cnt;
    int     test_err;
    int     test_cnt;
    int     test_fail;
    int     check_cnt;
    int     cycle_cnt;

    // shadow copy of the architectural state
    crmd_t       m_crmd;
    plv_ie_t     m_prmd;
    logic [12:0] m_ecfg;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;
    logic [31:0] m_eentry;
    logic [31:0] m_era;
    logic [31:0] m_badv;
    logic [31:0] m_tid;
    logic [31:0] m_save [4];
    logic        m_ti;

    csr_unit u_csr_unit (
        .clk    (clk),
        .rstn   (rstn),
        .req    (req),
        .stall  (stall),
        .flush  (flush),
        .hw_int (hw_int),
        .resp   (resp)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: simulation ran %0d cycles without finishing", CYCLE_LIMIT);
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic count_error();
        err_cnt++;
        test_err++;
    endtask

    task automatic check(string msg, logic [31:0] got, logic [31:0] exp);
        check_cnt++;
        if (got !== exp)
        begin
            $display("[FAIL] %0t ns: %s got %h expected %h", $time, msg, got, exp);
            count_error();
        end
    endtask

    task automatic end_test(string name);
        test_cnt++;
        if (test_err != 0)
            test_fail++;
        $display("test %0d %s: %s, %0d errors", test_cnt, name,
                 (test_err == 0) ? "ok" : "failed", test_err);
        test_err = 0;
    endtask

    function automatic ecode_e pick_ecode(int k);
        case (k % 11)
            0:       return PIL;
            1:       return PIS;
            2:       return PIF;
            3:       return PME;
            4:       return PPI;
            5:       return ADE;
            6:       return ALE;
            7:       return SYS;
            8:       return BRK;
            9:       return INE;
            default: return IPE;
        endcase
    endfunction

    function automatic csr_num_t rw_addr(int k);
        case (k % 7)
            0:       return CSR_SAVE0;
            1:       return CSR_SAVE1;
            2:       return CSR_SAVE2;
            3:       return CSR_SAVE3;
            4:       return CSR_ERA;
            5:       return CSR_TID;
            default: return CSR_EENTRY;
        endcase
    endfunction

    function automatic logic [31:0] model_read(csr_num_t num);
        case (num)
            CSR_CRMD:   return {23'b0, m_crmd};
            CSR_PRMD:   return {29'b0, m_prmd};
            CSR_ECFG:   return {19'b0, m_ecfg};
            CSR_ESTAT:  return {1'b0, m_esub, m_ecode, 3'b0, 1'b0, m_ti, 11'b0};
            CSR_ERA:    return m_era;
            CSR_BADV:   return m_badv;
            CSR_EENTRY: return m_eentry;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                return m_save[num[1:0]];
            CSR_TID:    return m_tid;
            default:    return '0;   // unimplemented, TICLR
        endcase
    endfunction

    task automatic model_write(csr_num_t num, logic [31:0] v);
        case (num)
            CSR_CRMD:   m_crmd = crmd_t'(v[8:0]);
            CSR_PRMD:   m_prmd = plv_ie_t'(v[2:0]);
            CSR_ECFG:   m_ecfg = v[12:0] & 13'h1bff;   // bit 10 reserved
            CSR_ERA:    m_era = v;
            CSR_BADV:   m_badv = v;
            CSR_EENTRY: m_eentry = {v[31:6], 6'b0};
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                m_save[num[1:0]] = v;
            CSR_TID:    m_tid = v;
            CSR_TICLR:  m_ti = v[0] ? 1'b0 : m_ti;
            default:    ;
        endcase
    endtask

    task automatic model_excp(logic [31:0] pc, ecode_e code, logic [8:0] sub,
                              logic [31:0] va);
        m_prmd      = '{ie: m_crmd.ie, plv: m_crmd.plv};
        m_crmd.ie   = 1'b0;
        m_crmd.plv  = 2'b00;
        m_era       = pc;
        m_ecode     = code;
        m_esub      = sub;
        if (code inside {ADE, ALE, PIL, PIS, PIF, PME, PPI})
            m_badv = va;
    endtask

    task automatic send(csr_op_e op, csr_num_t num, logic [31:0] wdata, logic [31:0] wmask,
                        logic [31:0] pc, ecode_e code, logic [8:0] sub, logic [31:0] va,
                        logic fl);
        @(negedge clk);
        req = '{valid: 1'b1, op: op, csr_num: num, wdata: wdata, wmask: wmask, pc: pc,
                ecode: code, esubcode: sub, bad_vaddr: va};
        flush = fl;
        @(negedge clk);
        req.valid = 1'b0;
        flush     = 1'b0;
    endtask

    task automatic wait_resp(output csr_resp_t r);
        int wait_cnt;
        wait_cnt = 0;
        while (!resp.valid && wait_cnt < 20)
        begin
            @(negedge clk);
            wait_cnt++;
        end
        r = resp;
        if (!resp.valid)
        begin
            $display("error at %0t ns: the DUT gave no response within 20 cycles", $time);
            count_error();
        end
        else
            check("response latency", wait_cnt, 1);   // two edges after acceptance
    endtask

    task automatic do_req(csr_op_e op, csr_num_t num, logic [31:0] wdata, logic [31:0] wmask,
                          logic [31:0] pc, ecode_e code, logic [8:0] sub, logic [31:0] va,
                          logic fl, output csr_resp_t r);
        send(op, num, wdata, wmask, pc, code, sub, va, fl);
        wait_resp(r);
    endtask

    task automatic csr_rd(csr_num_t num, output logic [31:0] d);
        csr_resp_t r;
        do_req(OP_CSRRD, num, '0, '0, 32'h1c00_0000, INT, '0, '0, 1'b0, r);
        check("read flush", r.flush, 1'b0);
        d = r.rdata;
    endtask

    task automatic read_check(csr_num_t num, string msg);
        logic [31:0] d;
        csr_rd(num, d);
        check(msg, d, model_read(num));
    endtask

    task automatic csr_wr(csr_num_t num, logic [31:0] d);
        csr_resp_t r;
        do_req(OP_CSRWR, num, d, '0, 32'h1c00_0100, INT, '0, '0, 1'b0, r);
        check("write flush", r.flush, 1'b1);
        model_write(num, d);
    endtask

    task automatic take_excp(logic fl, output ecode_e code);
        csr_resp_t   r;
        logic [31:0] pc;
        logic [31:0] va;
        logic [8:0]  sub;
        code = pick_ecode($unsigned($random(seed)) % 11);
        pc   = $random(seed);
        va   = $random(seed);
        sub  = 9'($random(seed));
        do_req(OP_EXCP, CSR_CRMD, '0, '0, pc, code, sub, va, fl, r);
        check("exception redirect", r.redirect_pc, m_eentry);
        check("exception flush", r.flush, 1'b1);
        check("exception int_taken", r.int_taken, 1'b0);
        model_excp(pc, code, sub, va);
    endtask

    initial
    begin
        int          i;
        int          n;
        int          len;
        int          initval;
        logic        got_int;
        logic        no_resp;
        logic [31:0] d;
        logic [31:0] old;
        logic [31:0] wdata;
        logic [31:0] wmask;
        logic [31:0] pc;
        csr_num_t    num;
        ecode_e      code;
        csr_resp_t   r;

        seed      = 41709;
        err_cnt   = 0;
        test_err  = 0;
        test_cnt  = 0;
        test_fail = 0;
        check_cnt = 0;
        req       = '0;
        stall     = 1'b0;
        flush     = 1'b0;
        hw_int    = 8'h00;
        rstn      = 1'b0;
        m_crmd    = crmd_t'(9'h008);   // da after reset
        m_prmd    = '0;
        m_ecfg    = '0;
        m_ecode   = '0;
        m_esub    = '0;
        m_eentry  = '0;
        m_ti      = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        for (i = 0; i < 7; i++)
            csr_wr(rw_addr(i), $random(seed));
        for (i = 0; i < N_ITER; i++)
        begin
            num = rw_addr($unsigned($random(seed)) % 7);
            csr_wr(num, $random(seed));
            read_check(num, "readback");
        end
        read_check(14'h020, "unimplemented cpuid");
        read_check(14'h060, "unimplemented llbctl");
        read_check(CSR_TICLR, "ticlr read");
        end_test("read/write");

        for (i = 0; i < N_ITER; i++)
        begin
            num   = csr_num_t'(CSR_SAVE0 | ($unsigned($random(seed)) % 4));
            wdata = $random(seed);
            wmask = $random(seed);
            pc    = $random(seed);
            old   = model_read(num);
            do_req(OP_CSRXCHG, num, wdata, wmask, pc, INT, '0, '0, 1'b0, r);
            check("xchg old value", r.rdata, old);
            check("xchg flush", r.flush, 1'b1);
            check("xchg redirect", r.redirect_pc, pc + 32'd4);
            model_write(num, (old & ~wmask) | (wdata & wmask));
            read_check(num, "xchg readback");
        end
        end_test("exchange");

        for (i = 0; i < N_ITER / 2; i++)
        begin
            csr_wr(CSR_CRMD, $random(seed));   // random plv/ie, lie still zero
            take_excp(1'b0, code);
            read_check(CSR_ERA, "era after exception");
            read_check(CSR_ESTAT, "estat after exception");
            read_check(CSR_PRMD, "prmd after exception");
            read_check(CSR_CRMD, "crmd after exception");
            if (code == ADE || code == ALE)
                read_check(CSR_BADV, "badv after exception");
        end
        end_test("exception");

        for (i = 0; i < N_ITER / 2; i++)
        begin
            csr_wr(CSR_CRMD, $random(seed));
            take_excp(1'b0, code);
            pc = $random(seed);
            do_req(OP_ERTN, CSR_CRMD, '0, '0, pc, INT, '0, '0, 1'b0, r);
            check("ertn redirect", r.redirect_pc, m_era);
            check("ertn flush", r.flush, 1'b1);
            m_crmd.plv = m_prmd.plv;
            m_crmd.ie  = m_prmd.ie;
            read_check(CSR_CRMD, "crmd after ertn");
        end
        end_test("ertn");

        csr_wr(CSR_ECFG, 32'h0000_0800);   // timer line only
        csr_wr(CSR_CRMD, 32'h0000_000c);   // plv0 with ie
        initval = 1 + $unsigned($random(seed)) % 8;
        csr_wr(CSR_TCFG, (initval << 2) | 32'h1);   // one-shot
        got_int = 1'b0;
        n       = 0;
        while (!got_int && n < initval * 4 + 20)
        begin
            pc = $random(seed);
            do_req(OP_NONE, CSR_CRMD, '0, '0, pc, INT, '0, '0, 1'b0, r);
            if (r.int_taken)
            begin
                got_int = 1'b1;
                check("interrupt redirect", r.redirect_pc, m_eentry);
                check("interrupt flush", r.flush, 1'b1);
                m_ti = 1'b1;
                model_excp(pc, INT, '0, '0);
            end
            else
            begin
                check("plain op flush", r.flush, 1'b0);
                check("plain op redirect", r.redirect_pc, pc + 32'd4);
            end
            n++;
        end
        if (!got_int)
        begin
            $display("error at %0t ns: the timer interrupt was never taken", $time);
            count_error();
        end
        csr_rd(CSR_ESTAT, d);
        check("estat timer bit", d[LIE_TIMER_BIT], 1'b1);
        check("estat ecode", d[21:16], INT);
        read_check(CSR_ERA, "era at interrupt");
        csr_wr(CSR_TICLR, 32'h1);
        read_check(CSR_ESTAT, "estat after ticlr");
        end_test("timer interrupt");

        old = m_save[2];
        send(OP_CSRWR, CSR_SAVE2, ~old, '0, 32'h1c00_0300, INT, '0, '0, 1'b1);
        no_resp = 1'b1;
        repeat (6)
        begin
            @(negedge clk);
            if (resp.valid)
                no_resp = 1'b0;
        end
        check("flushed write gave no response", no_resp, 1'b1);
        read_check(CSR_SAVE2, "flushed write left save2");
        take_excp(1'b1, code);   // flush never kills an exception
        read_check(CSR_ERA, "era after flushed exception");
        for (i = 0; i < 8; i++)
        begin
            num = rw_addr($unsigned($random(seed)) % 7);
            send(OP_CSRRD, num, '0, '0, 32'h1c00_0400, INT, '0, '0, 1'b0);
            wait_resp(r);
            check("stalled read data", r.rdata, model_read(num));
            check("stalled read redirect", r.redirect_pc, 32'h1c00_0404);
            stall       = 1'b1;
            req.csr_num = (num == CSR_TID) ? CSR_ERA : CSR_TID;   // other data behind the stall
            req.pc      = ~req.pc;
            len         = 1 + $unsigned($random(seed)) % 8;
            repeat (len)
            begin
                @(negedge clk);
                check("valid held in stall", resp.valid, 1'b1);
                check("rdata held in stall", resp.rdata, r.rdata);
                check("redirect held in stall", resp.redirect_pc, r.redirect_pc);
            end
            stall = 1'b0;
            @(negedge clk);
            check("valid after stall", resp.valid, 1'b0);
        end
        end_test("flush and stall");

        $display("done: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_cnt, test_fail, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/csr_arch_pkg.sv ====
`default_nettype none

package csr_arch_pkg;

    localparam int CSR_NUM_W = 14;
    localparam int TIMER_W   = 32;

    typedef logic [CSR_NUM_W-1:0] csr_num_t;

    localparam csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_num_t CSR_ECFG   = 14'h004;
    localparam csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_num_t CSR_ERA    = 14'h006;
    localparam csr_num_t CSR_BADV   = 14'h007;
    localparam csr_num_t CSR_EENTRY = 14'h00c;
    localparam csr_num_t CSR_SAVE0  = 14'h030;
    localparam csr_num_t CSR_SAVE1  = 14'h031;
    localparam csr_num_t CSR_SAVE2  = 14'h032;
    localparam csr_num_t CSR_SAVE3  = 14'h033;
    localparam csr_num_t CSR_TID    = 14'h040;
    localparam csr_num_t CSR_TCFG   = 14'h041;
    localparam csr_num_t CSR_TVAL   = 14'h042;
    localparam csr_num_t CSR_TICLR  = 14'h044;

    localparam int          LIE_TIMER_BIT = 11;
    localparam logic [12:0] ECFG_LIE_MASK = 13'h1bff;   // bit 10 reserved

    // msb first, so the struct matches the register layout
    typedef struct packed {
        logic [1:0] datm;
        logic [1:0] datf;
        logic       pg;
        logic       da;
        logic       ie;
        logic [1:0] plv;
    } crmd_t;

    localparam crmd_t CRMD_RESET = 9'b0_0000_1000;   // direct address mode

    typedef struct packed {
        logic       ie;
        logic [1:0] plv;
    } plv_ie_t;

    typedef enum logic [5:0] {
        INT = 6'h00, PIL = 6'h01, PIS = 6'h02, PIF = 6'h03,
        PME = 6'h04, PPI = 6'h07, ADE = 6'h08, ALE = 6'h09,
        SYS = 6'h0b, BRK = 6'h0c, INE = 6'h0d, IPE = 6'h0e
    } ecode_e;

    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

    typedef struct packed {
        logic  valid;
        tcfg_t cfg;
    } tcfg_wr_t;

    typedef struct packed {
        tcfg_t              tcfg;
        logic [TIMER_W-1:0] tval;
        logic               ti;
    } timer_state_t;

endpackage

`default_nettype wire

// ==== verilog/csr_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_decode (
    input  logic                   clk,
    input  logic                   rstn,
    input  csr_pipe_pkg::csr_req_t req,
    input  logic                   stall,
    input  logic                   flush,
    input  logic                   irq_pending,
    output csr_pipe_pkg::csr_cmd_t cmd
);
    import csr_arch_pkg::*;
    import csr_pipe_pkg::*;

    csr_cmd_t next_cmd;
    csr_cmd_t cmd_q;
    logic     cmd_valid;
    logic     kill;

    always_comb
    begin
        next_cmd.valid     = req.valid;
        next_cmd.op        = req.op;
        next_cmd.int_taken = 1'b0;
        next_cmd.csr_num   = req.csr_num;
        next_cmd.wdata     = req.wdata;
        next_cmd.wmask     = req.wmask;
        next_cmd.pc        = req.pc;
        next_cmd.ecode     = req.ecode;
        next_cmd.esubcode  = req.esubcode;
        next_cmd.bad_vaddr = req.bad_vaddr;

        if (irq_pending)
        begin
            // interrupt wins over whatever the instruction is
            next_cmd.op        = OP_EXCP;
            next_cmd.ecode     = INT;
            next_cmd.esubcode  = '0;
            next_cmd.int_taken = 1'b1;
        end
        else if (req.op != OP_EXCP)
        begin
            next_cmd.esubcode  = '0;   // plain op, no exception info
        end
    end

    // flush drops everything except exceptions and interrupts
    assign kill = flush & ~(req.op == OP_EXCP || irq_pending);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            cmd_valid <= 1'b0;
        end
        else if (!stall)
        begin
            cmd_valid <= req.valid & ~kill;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            cmd_q <= next_cmd;
        end
    end

    always_comb
    begin
        cmd       = cmd_q;
        cmd.valid = cmd_valid;
    end

endmodule

`default_nettype wire

// ==== verilog/csr_pipe_pkg.sv ====
`default_nettype none

package csr_pipe_pkg;

    // OP_NONE is an ordinary instruction, still a carrier for interrupts
    typedef enum logic [2:0] {
        OP_NONE    = 3'd0,
        OP_CSRRD   = 3'd1,
        OP_CSRWR   = 3'd2,
        OP_CSRXCHG = 3'd3,
        OP_ERTN    = 3'd4,
        OP_EXCP    = 3'd5
    } csr_op_e;

    typedef struct packed {
        logic                   valid;
        csr_op_e                op;
        csr_arch_pkg::csr_num_t csr_num;
        logic [31:0]            wdata;
        logic [31:0]            wmask;     // xchg only
        logic [31:0]            pc;
        csr_arch_pkg::ecode_e   ecode;
        logic [8:0]             esubcode;
        logic [31:0]            bad_vaddr;
    } csr_req_t;

    typedef struct packed {
        logic                   valid;
        csr_op_e                op;
        logic                   int_taken;
        csr_arch_pkg::csr_num_t csr_num;
        logic [31:0]            wdata;
        logic [31:0]            wmask;
        logic [31:0]            pc;
        csr_arch_pkg::ecode_e   ecode;
        logic [8:0]             esubcode;
        logic [31:0]            bad_vaddr;
    } csr_cmd_t;

    typedef struct packed {
        logic        valid;
        logic        flush;
        logic        int_taken;
        logic [31:0] redirect_pc;
        logic [31:0] rdata;
    } csr_resp_t;

endpackage

`default_nettype wire

// ==== verilog/csr_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_regfile (
    input  logic                       clk,
    input  logic                       rstn,
    input  csr_pipe_pkg::csr_cmd_t     cmd,
    input  logic                       stall,
    input  logic [7:0]                 hw_int,
    input  csr_arch_pkg::timer_state_t timer,
    output logic                       irq_pending,
    output csr_arch_pkg::tcfg_wr_t     tcfg_wr,
    output logic                       ti_clear,
    output csr_pipe_pkg::csr_resp_t    resp
);
    import csr_arch_pkg::*;
    import csr_pipe_pkg::*;

    crmd_t       crmd;
    plv_ie_t     prmd;
    logic [12:0] ecfg_lie;
    logic [1:0]  estat_sw;
    ecode_e      estat_ecode;
    logic [8:0]  estat_esubcode;
    logic [31:6] eentry;
    logic [31:0] era;
    logic [31:0] badv;
    logic [31:0] save [4];
    logic [31:0] tid;

    logic [12:0] estat_is;
    logic [31:0] rd_val;
    logic [31:0] wr_mask;
    logic [31:0] wr_val;
    logic [31:0] next_pc;
    logic        commit;
    logic        csr_wr;
    logic        badv_upd;

    logic        resp_valid;
    logic        resp_flush;
    logic        resp_int;
    logic [31:0] resp_pc;
    logic [31:0] resp_rdata;

    // ipi, ti, reserved, hw lines, sw bits
    assign estat_is    = {1'b0, timer.ti, 1'b0, hw_int, estat_sw};
    assign irq_pending = crmd.ie & (|(estat_is & ecfg_lie));

    always_comb
    begin
        case (cmd.csr_num)
            CSR_CRMD:   rd_val = {23'b0, crmd};
            CSR_PRMD:   rd_val = {29'b0, prmd};
            CSR_ECFG:   rd_val = {19'b0, ecfg_lie};
            CSR_ESTAT:  rd_val = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
            CSR_ERA:    rd_val = era;
            CSR_BADV:   rd_val = badv;
            CSR_EENTRY: rd_val = {eentry, 6'b0};
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                rd_val = save[cmd.csr_num[1:0]];
            CSR_TID:    rd_val = tid;
            CSR_TCFG:   rd_val = timer.tcfg;
            CSR_TVAL:   rd_val = timer.tval;
            default:    rd_val = '0;   // includes TICLR
        endcase
    end

    assign commit  = cmd.valid & ~stall;
    assign csr_wr  = commit & (cmd.op == OP_CSRWR || cmd.op == OP_CSRXCHG);
    assign wr_mask = (cmd.op == OP_CSRXCHG) ? cmd.wmask : '1;
    assign wr_val  = (rd_val & ~wr_mask) | (cmd.wdata & wr_mask);

    assign tcfg_wr  = '{valid: csr_wr && cmd.csr_num == CSR_TCFG, cfg: tcfg_t'(wr_val)};
    assign ti_clear = csr_wr && cmd.csr_num == CSR_TICLR && wr_val[0];

    // address related faults only
    assign badv_upd = cmd.ecode inside {ADE, ALE, PIL, PIS, PIF, PME, PPI};

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd           <= CRMD_RESET;
            prmd           <= '0;
            ecfg_lie       <= '0;
            estat_sw       <= '0;
            estat_ecode    <= INT;
            estat_esubcode <= '0;
            eentry         <= '0;
        end
        else if (commit)
        begin
            case (cmd.op)
                OP_CSRWR, OP_CSRXCHG:
                    case (cmd.csr_num)
                        CSR_CRMD:   crmd <= crmd_t'(wr_val[8:0]);
                        CSR_PRMD:   prmd <= plv_ie_t'(wr_val[2:0]);
                        CSR_ECFG:   ecfg_lie <= wr_val[12:0] & ECFG_LIE_MASK;
                        CSR_ESTAT:  estat_sw <= wr_val[1:0];
                        CSR_EENTRY: eentry <= wr_val[31:6];
                        default:    ;
                    endcase
                OP_EXCP:
                begin
                    prmd           <= '{ie: crmd.ie, plv: crmd.plv};
                    crmd.plv       <= 2'b00;
                    crmd.ie        <= 1'b0;
                    estat_ecode    <= cmd.ecode;
                    estat_esubcode <= cmd.esubcode;
                end
                OP_ERTN:
                begin
                    crmd.plv <= prmd.plv;
                    crmd.ie  <= prmd.ie;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (commit && csr_wr)
        begin
            case (cmd.csr_num)
                CSR_ERA:  era <= wr_val;
                CSR_BADV: badv <= wr_val;
                CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                    save[cmd.csr_num[1:0]] <= wr_val;
                CSR_TID:  tid <= wr_val;
                default:  ;
            endcase
        end
        else if (commit && cmd.op == OP_EXCP)
        begin
            era <= cmd.pc;
            if (badv_upd)
                badv <= cmd.bad_vaddr;
        end
    end

    always_comb
    begin
        case (cmd.op)
            OP_ERTN: next_pc = era;
            OP_EXCP: next_pc = {eentry, 6'b0};
            default: next_pc = cmd.pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            resp_valid <= 1'b0;
            resp_flush <= 1'b0;
            resp_int   <= 1'b0;
        end
        else if (!stall)
        begin
            resp_valid <= cmd.valid;
            resp_flush <= cmd.valid && !(cmd.op == OP_CSRRD || cmd.op == OP_NONE);
            resp_int   <= cmd.valid && cmd.int_taken;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            resp_pc    <= next_pc;
            resp_rdata <= rd_val;   // old value, also for xchg
        end
    end

    assign resp = '{valid: resp_valid, flush: resp_flush, int_taken: resp_int,
                    redirect_pc: resp_pc, rdata: resp_rdata};

endmodule

`default_nettype wire

// ==== verilog/csr_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_timer (
    input  logic                       clk,
    input  logic                       rstn,
    input  csr_arch_pkg::tcfg_wr_t     tcfg_wr,
    input  logic                       ti_clear,
    output csr_arch_pkg::timer_state_t timer
);
    import csr_arch_pkg::*;

    tcfg_t              tcfg;
    logic [TIMER_W-1:0] tval;
    logic               ti;
    logic               reload;   // tcfg written last cycle

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg   <= '0;
            reload <= 1'b0;
        end
        else
        begin
            reload <= tcfg_wr.valid;
            if (tcfg_wr.valid)
                tcfg <= tcfg_wr.cfg;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
            tval <= '0;
        else if (tcfg.en && (reload || (tval == '0 && tcfg.periodic)))
            tval <= {tcfg.initval, 2'b00};
        else if (!tcfg.en)
            tval <= '0;
        else if (tval != '1)
            tval <= tval - 1'b1;   // one-shot parks at all ones after wrap
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
            ti <= 1'b0;
        else if (ti_clear)
            ti <= 1'b0;
        else if (tcfg.en && tval == '0 && !reload)
            ti <= 1'b1;
    end

    assign timer = '{tcfg: tcfg, tval: tval, ti: ti};

endmodule

`default_nettype wire

// ==== verilog/csr_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_unit (
    input  logic                    clk,
    input  logic                    rstn,
    input  csr_pipe_pkg::csr_req_t  req,
    input  logic                    stall,
    input  logic                    flush,
    input  logic [7:0]              hw_int,
    output csr_pipe_pkg::csr_resp_t resp
);
    import csr_arch_pkg::*;
    import csr_pipe_pkg::*;

    csr_cmd_t     cmd;
    logic         irq_pending;
    tcfg_wr_t     tcfg_wr;
    logic         ti_clear;
    timer_state_t timer;

    // capture stage, one cycle
    csr_decode u_csr_decode (
        .clk         (clk),
        .rstn        (rstn),
        .req         (req),
        .stall       (stall),
        .flush       (flush),
        .irq_pending (irq_pending),
        .cmd         (cmd)
    );

    csr_regfile u_csr_regfile (
        .clk         (clk),
        .rstn        (rstn),
        .cmd         (cmd),
        .stall       (stall),
        .hw_int      (hw_int),
        .timer       (timer),
        .irq_pending (irq_pending),
        .tcfg_wr     (tcfg_wr),
        .ti_clear    (ti_clear),
        .resp        (resp)
    );

    csr_timer u_csr_timer (
        .clk      (clk),
        .rstn     (rstn),
        .tcfg_wr  (tcfg_wr),
        .ti_clear (ti_clear),
        .timer    (timer)
    );

endmodule

`default_nettype wire
